// File: hdl/cpri_rx_pkg.sv
/*
 * CPRI uplink receive buffer definitions
 * Word and buffer geometry, header field layout, uplink filter
 * constants and the header filter state encoding
 */
`default_nettype none

package cpri_rx_pkg;

    // ------------------------------------------------------------
    // Link word and buffer geometry
    // ------------------------------------------------------------
    localparam int WORD_W     = 64;
    localparam int SYMB_WORDS = 192;
    localparam int CHIP_WORDS = 96;
    localparam int BUF_SYMBS  = 4;
    localparam int BUF_WORDS  = BUF_SYMBS * SYMB_WORDS;

    typedef logic [WORD_W-1:0] cpri_word_t;
    typedef logic [9:0]        buf_addr_t;
    typedef logic [6:0]        chip_addr_t;
    typedef logic [7:0]        symb_pos_t;
    typedef logic [2:0]        level_t;
    typedef logic [31:0]       agc_t;

    // ------------------------------------------------------------
    // Header fields
    // ------------------------------------------------------------
    typedef logic [3:0] pkg_type_t;
    typedef logic [7:0] prb_t;
    typedef logic [6:0] slot_t;
    typedef logic [3:0] symb_t;

    localparam int HDR_PKG_LSB  = 36;
    localparam int HDR_PRB0_LSB = 28;
    localparam int HDR_PRB1_LSB = 20;
    localparam int HDR_SLOT_LSB = 12;
    localparam int HDR_SYMB_LSB = 8;

    // Uplink filter and start condition
    localparam pkg_type_t PUSCH_PKG_TYPE = 4'd8;
    localparam int        UL_SLOT_PERIOD = 5;
    localparam int        UL_SLOT_PHASE  = 4;
    localparam int        UL_SLOT_COUNT  = 80;
    localparam prb_t      SOP_PRB0       = 8'd0;
    localparam prb_t      SOP_PRB1       = 8'd4;

    // Word within a symbol whose upper half holds the AGC value
    localparam int AGC_WORD = 4;

    typedef enum logic [1:0] {
        ST_HDR,
        ST_KEEP,
        ST_SKIP
    } filt_state_t;

endpackage

`default_nettype wire

// File: hdl/cpri_hdr_filter.sv
/*
 * CPRI uplink header filter
 * Parses each symbol header, keeps uplink data symbols in uplink
 * slots once the stream start has been seen, and forwards kept
 * payload words to the buffer write port
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_hdr_filter import cpri_rx_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       cpri_reset,
    input  wire logic       i_enable,
    input  wire logic       i_rvalid,
    input  wire cpri_word_t i_rx_data,
    input  wire logic       i_buf_full,
    output logic            o_rx_sop,
    output logic            o_wr_en,
    output cpri_word_t      o_wr_data
);

    filt_state_t state;
    symb_pos_t   word_cnt;
    pkg_type_t   hdr_pkg;
    prb_t        hdr_prb0;
    prb_t        hdr_prb1;
    slot_t       hdr_slot;
    symb_t       hdr_symb;
    logic        hdr_vld;
    logic        slot_ok;
    logic        start_ok;
    logic        hdr_ok;
    logic        keep;

    // ------------------------------------------------------------
    // Header decode
    // ------------------------------------------------------------
    assign hdr_pkg  = i_rx_data[HDR_PKG_LSB +: $bits(pkg_type_t)];
    assign hdr_prb0 = i_rx_data[HDR_PRB0_LSB +: $bits(prb_t)];
    assign hdr_prb1 = i_rx_data[HDR_PRB1_LSB +: $bits(prb_t)];
    assign hdr_slot = i_rx_data[HDR_SLOT_LSB +: $bits(slot_t)];
    assign hdr_symb = i_rx_data[HDR_SYMB_LSB +: $bits(symb_t)];

    assign hdr_vld  = i_rvalid && (state == ST_HDR);

    // Uplink slots are 4, 9, 14 ... 79
    assign slot_ok  = (hdr_slot < UL_SLOT_COUNT) &&
                      ((hdr_slot % UL_SLOT_PERIOD) == UL_SLOT_PHASE);
    assign start_ok = (hdr_symb == '0) && (hdr_prb0 == SOP_PRB0) &&
                      (hdr_prb1 == SOP_PRB1);
    assign hdr_ok   = (hdr_pkg == PUSCH_PKG_TYPE) && slot_ok && i_enable && !i_buf_full;
    // Nothing is kept until the start symbol has been seen
    assign keep     = hdr_ok && (o_rx_sop || start_ok);

    // ------------------------------------------------------------
    // Symbol framing
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            state    <= ST_HDR;
            word_cnt <= '0;
        end else if (i_rvalid) begin
            case (state)
                ST_HDR: begin
                    state    <= keep ? ST_KEEP : ST_SKIP;
                    word_cnt <= '0;
                end
                default: begin
                    if (word_cnt == symb_pos_t'(SYMB_WORDS - 1)) begin
                        state <= ST_HDR;
                    end
                    word_cnt <= word_cnt + 1'b1;
                end
            endcase
        end
    end

    // Start of stream, dropped as soon as the link is disabled
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            o_rx_sop <= 1'b0;
        end else if (!i_enable) begin
            o_rx_sop <= 1'b0;
        end else if (hdr_vld && hdr_ok && start_ok) begin
            o_rx_sop <= 1'b1;
        end
    end

    // Payload write strobe, one cycle behind the link
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_rvalid && (state == ST_KEEP);
        end
    end

    always_ff @(posedge i_clk) begin
        o_wr_data <= i_rx_data;
    end

endmodule

`default_nettype wire

// File: hdl/cpri_symb_writer.sv
/*
 * Symbol ring write side
 * Steps the RAM write address around the ring and flags the last
 * payload word of every stored symbol
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_symb_writer import cpri_rx_pkg::*; (
    input  wire logic i_clk,
    input  wire logic cpri_reset,
    input  wire logic i_wr_en,
    output buf_addr_t o_wr_addr,
    output logic      o_wr_symb_done
);

    symb_pos_t wr_pos;
    logic      pos_last;

    assign pos_last       = (wr_pos == symb_pos_t'(SYMB_WORDS - 1));
    // High together with the write of the last word
    assign o_wr_symb_done = i_wr_en && pos_last;

    // Ring address, wraps at the full RAM depth
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            o_wr_addr <= '0;
        end else if (i_wr_en) begin
            if (o_wr_addr == buf_addr_t'(BUF_WORDS - 1)) begin
                o_wr_addr <= '0;
            end else begin
                o_wr_addr <= o_wr_addr + 1'b1;
            end
        end
    end

    // Word position inside the current symbol
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            wr_pos <= '0;
        end else if (i_wr_en) begin
            wr_pos <= pos_last ? '0 : wr_pos + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpri_buf_level.sv
/*
 * Buffer fill level
 * Counts complete symbols not yet read and derives the full and
 * data-available levels
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_buf_level import cpri_rx_pkg::*; (
    input  wire logic i_clk,
    input  wire logic cpri_reset,
    input  wire logic i_wr_symb_done,
    input  wire logic i_rd_symb_done,
    output logic      o_buf_full,
    output logic      o_rd_vld
);

    level_t symb_cnt;
    level_t symb_cnt_nxt;

    always_comb begin
        case ({i_wr_symb_done, i_rd_symb_done})
            2'b10:   symb_cnt_nxt = symb_cnt + 1'b1;
            2'b01:   symb_cnt_nxt = symb_cnt - 1'b1;
            default: symb_cnt_nxt = symb_cnt;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            symb_cnt <= '0;
        end else begin
            symb_cnt <= symb_cnt_nxt;
        end
    end

    // Full looks at the next count so a header right behind a
    // completing symbol already sees it
    assign o_buf_full = (symb_cnt_nxt == level_t'(BUF_SYMBS));
    assign o_rd_vld   = (symb_cnt != '0);

endmodule

`default_nettype wire

// File: hdl/cpri_symb_ram.sv
/*
 * Symbol RAM
 * Simple dual-port memory for four symbols, registered read
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_symb_ram import cpri_rx_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_wr_en,
    input  wire buf_addr_t  i_wr_addr,
    input  wire cpri_word_t i_wr_data,
    input  wire buf_addr_t  i_rd_addr,
    output cpri_word_t      o_rd_data
);

    cpri_word_t mem [BUF_WORDS];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

// File: hdl/cpri_symb_reader.sv
/*
 * Symbol ring read side
 * Drains stored symbols word by word as numbered chips, marks chip
 * and symbol ends and captures the AGC word of each symbol
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_symb_reader import cpri_rx_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       cpri_reset,
    input  wire logic       i_rd_en,
    input  wire logic       i_rready,
    input  wire logic       i_rd_vld,
    input  wire cpri_word_t i_rd_data,
    output buf_addr_t       o_rd_addr,
    output logic            o_rd_symb_done,
    output logic            o_tvalid,
    output cpri_word_t      o_tx_data,
    output chip_addr_t      o_tx_addr,
    output logic            o_tx_last,
    output logic            o_symb_eop,
    output agc_t            o_fft_agc
);

    logic       rd_req;
    symb_pos_t  rd_pos;
    chip_addr_t chip_pos;
    logic       pos_last;
    logic       chip_last;

    // Flags travelling beside the RAM read
    logic       s1_vld;
    chip_addr_t s1_chip;
    logic       s1_last;
    logic       s1_eop;
    logic       s1_agc;

    assign rd_req         = i_rd_en && i_rready && i_rd_vld;
    assign pos_last       = (rd_pos == symb_pos_t'(SYMB_WORDS - 1));
    assign chip_last      = (chip_pos == chip_addr_t'(CHIP_WORDS - 1));
    assign o_rd_symb_done = rd_req && pos_last;

    // ------------------------------------------------------------
    // Address generation
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            o_rd_addr <= '0;
            rd_pos    <= '0;
            chip_pos  <= '0;
        end else if (rd_req) begin
            if (o_rd_addr == buf_addr_t'(BUF_WORDS - 1)) begin
                o_rd_addr <= '0;
            end else begin
                o_rd_addr <= o_rd_addr + 1'b1;
            end
            rd_pos   <= pos_last ? '0 : rd_pos + 1'b1;
            chip_pos <= chip_last ? '0 : chip_pos + 1'b1;
        end
    end

    // RAM read stage
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= rd_req;
        end
        s1_chip <= chip_pos;
        s1_last <= chip_last;
        s1_eop  <= pos_last;
        s1_agc  <= (rd_pos == symb_pos_t'(AGC_WORD));
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            o_tvalid   <= 1'b0;
            o_tx_last  <= 1'b0;
            o_symb_eop <= 1'b0;
            o_fft_agc  <= '0;
        end else begin
            o_tvalid   <= s1_vld;
            o_tx_last  <= s1_vld && s1_last;
            o_symb_eop <= s1_vld && s1_eop;
            if (s1_vld && s1_agc) begin
                o_fft_agc <= i_rd_data[WORD_W-1 -: $bits(agc_t)];
            end
        end
        o_tx_data <= i_rd_data;
        o_tx_addr <= s1_chip;
    end

endmodule

`default_nettype wire

// File: hdl/cpri_rx_buffer.sv
/*
 * CPRI uplink receive buffer
 * Filters uplink symbols from the link, stores them in a four-symbol
 * ring and plays them out as chips of 96 words
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_rx_buffer import cpri_rx_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       cpri_reset,
    input  wire logic       i_enable,
    input  wire cpri_word_t i_rx_data,
    input  wire logic       i_rvalid,
    input  wire logic       i_rd_en,
    input  wire logic       i_rready,
    output logic            o_rd_vld,
    output logic            o_rx_sop,
    output logic            o_tready,
    output logic            o_tvalid,
    output cpri_word_t      o_tx_data,
    output chip_addr_t      o_tx_addr,
    output logic            o_tx_last,
    output logic            o_symb_eop,
    output agc_t            o_fft_agc
);

    logic       wr_en;
    cpri_word_t wr_data;
    buf_addr_t  wr_addr;
    logic       wr_symb_done;
    logic       buf_full;
    buf_addr_t  rd_addr;
    cpri_word_t rd_data;
    logic       rd_symb_done;

    assign o_tready = ~buf_full;

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    cpri_hdr_filter u_filter (
        .i_clk(i_clk), .cpri_reset(cpri_reset), .i_enable(i_enable),
        .i_rvalid(i_rvalid), .i_rx_data(i_rx_data), .i_buf_full(buf_full),
        .o_rx_sop(o_rx_sop), .o_wr_en(wr_en), .o_wr_data(wr_data)
    );

    cpri_symb_writer u_writer (
        .i_clk(i_clk), .cpri_reset(cpri_reset), .i_wr_en(wr_en),
        .o_wr_addr(wr_addr), .o_wr_symb_done(wr_symb_done)
    );

    cpri_buf_level u_level (
        .i_clk(i_clk), .cpri_reset(cpri_reset),
        .i_wr_symb_done(wr_symb_done), .i_rd_symb_done(rd_symb_done),
        .o_buf_full(buf_full), .o_rd_vld(o_rd_vld)
    );

    cpri_symb_ram u_ram (
        .i_clk(i_clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
        .i_wr_data(wr_data), .i_rd_addr(rd_addr), .o_rd_data(rd_data)
    );

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    cpri_symb_reader u_reader (
        .i_clk(i_clk), .cpri_reset(cpri_reset), .i_rd_en(i_rd_en),
        .i_rready(i_rready), .i_rd_vld(o_rd_vld), .i_rd_data(rd_data),
        .o_rd_addr(rd_addr), .o_rd_symb_done(rd_symb_done),
        .o_tvalid(o_tvalid), .o_tx_data(o_tx_data), .o_tx_addr(o_tx_addr),
        .o_tx_last(o_tx_last), .o_symb_eop(o_symb_eop), .o_fft_agc(o_fft_agc)
    );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
/*
 * Testbench clock generator
 * Free-running clock with a 10 ns period
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);

    localparam real HALF_PERIOD = 5.0;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// File: verif/cpri_rx_checker.sv
/*
 * CPRI receive buffer checker
 * Queues the payload words the testbench expects to be kept and
 * compares every DUT output word, its chip flags and the AGC value
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_rx_checker import cpri_rx_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       cpri_reset,
    input  wire logic       i_rd_vld,
    input  wire logic       i_rx_sop,
    input  wire logic       i_tready,
    input  wire logic       i_tvalid,
    input  wire cpri_word_t i_tx_data,
    input  wire chip_addr_t i_tx_addr,
    input  wire logic       i_tx_last,
    input  wire logic       i_symb_eop,
    input  wire agc_t       i_fft_agc,
    input  wire logic       i_exp_vld,
    input  wire cpri_word_t i_exp_word,
    input  wire logic       i_hdr_chk,
    input  wire logic       i_exp_sop,
    input  wire logic       i_exp_full,
    output int              o_err_cnt,
    output int              o_chk_cnt,
    output int              o_pending,
    output int              o_symb_cnt
);

    cpri_word_t exp_q [$];
    cpri_word_t exp_word;
    agc_t       exp_agc  = '0;
    logic       rst_d;
    int         out_pos  = 0;
    int         err_cnt  = 0;
    int         chk_cnt  = 0;
    int         symb_cnt = 0;
    int         pending  = 0;

    assign o_err_cnt  = err_cnt;
    assign o_chk_cnt  = chk_cnt;
    assign o_pending  = pending;
    assign o_symb_cnt = symb_cnt;

    task automatic check_val(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
        chk_cnt++;
        if (exp_val !== act_val) begin
            err_cnt++;
            $display("FAILED %s: expected %0h, actual %0h (at %0t)",
                     name, exp_val, act_val, $time);
        end
    endtask

    // Values right after the last reset edge
    task automatic check_reset();
        check_val("reset tvalid", 64'd0, 64'(i_tvalid));
        check_val("reset rd_vld", 64'd0, 64'(i_rd_vld));
        check_val("reset rx_sop", 64'd0, 64'(i_rx_sop));
        check_val("reset symb_eop", 64'd0, 64'(i_symb_eop));
        check_val("reset tx_last", 64'd0, 64'(i_tx_last));
        check_val("reset tready", 64'd1, 64'(i_tready));
        check_val("reset fft_agc", 64'd0, 64'(i_fft_agc));
    endtask

    // ------------------------------------------------------------
    // Output word against the expected stream
    // ------------------------------------------------------------
    task automatic check_word();
        int chip_pos;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("Output word %h appeared while no kept symbol was pending (at %0t)",
                     i_tx_data, $time);
        end else begin
            exp_word = exp_q.pop_front();
            chip_pos = out_pos % CHIP_WORDS;
            check_val("tx_data", exp_word, i_tx_data);
            check_val("tx_addr", 64'(chip_pos), 64'(i_tx_addr));
            check_val("tx_last", 64'(chip_pos == CHIP_WORDS - 1), 64'(i_tx_last));
            check_val("symb_eop", 64'(out_pos == SYMB_WORDS - 1), 64'(i_symb_eop));
            if (out_pos == AGC_WORD) begin
                exp_agc = exp_word[WORD_W-1 -: 32];
            end
            if (out_pos == SYMB_WORDS - 1) begin
                check_val("fft_agc", 64'(exp_agc), 64'(i_fft_agc));
                out_pos = 0;
                symb_cnt++;
            end else begin
                out_pos++;
            end
        end
    endtask

    always @(posedge i_clk) begin
        rst_d <= cpri_reset;
        if (rst_d === 1'b1 && cpri_reset === 1'b0) begin
            check_reset();
        end
        if (cpri_reset === 1'b0) begin
            if (i_exp_vld) begin
                exp_q.push_back(i_exp_word);
            end
            // Header was sampled one edge earlier
            if (i_hdr_chk) begin
                check_val("rx_sop", 64'(i_exp_sop), 64'(i_rx_sop));
                check_val("tready", 64'(!i_exp_full), 64'(i_tready));
            end
            if (i_tvalid) begin
                check_word();
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// File: verif/cpri_rx_tb.sv
/*
 * CPRI uplink receive buffer testbench
 * Sends a table of symbols through the header filter and checks
 * playout order, back-pressure, the full buffer and the ring wrap
 */
`timescale 1ns/100ps
`default_nettype none

module cpri_rx_tb import cpri_rx_pkg::*; ();

    typedef struct packed {
        pkg_type_t pkg;
        slot_t     slot;
        symb_t     symb;
        prb_t      prb0;
        prb_t      prb1;
        logic      en;
        logic      rd;
        logic      keep;
        logic      sop;
        logic      full;
    } entry_t;

    localparam int N_ENTRIES   = 23;
    localparam int DRAIN_LIMIT = 6000;

    // pkg, slot, symb, prb0, prb1, enable, read, keep, sop, full
    localparam entry_t STIM [N_ENTRIES] = '{
        // Filter and stream start, entries 0 to 12
        '{4'd8, 7'd4,  4'd1, 8'd0, 8'd4, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{4'd8, 7'd4,  4'd0, 8'd0, 8'd4, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{4'd3, 7'd9,  4'd0, 8'd0, 8'd4, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{4'd8, 7'd7,  4'd0, 8'd0, 8'd4, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{4'd8, 7'd84, 4'd0, 8'd0, 8'd4, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{4'd8, 7'd9,  4'd0, 8'd0, 8'd4, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd14, 4'd3, 8'd2, 8'd9, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd10, 4'd1, 8'd5, 8'd5, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},
        '{4'd8, 7'd19, 4'd2, 8'd1, 8'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{4'd8, 7'd24, 4'd5, 8'd3, 8'd3, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{4'd8, 7'd24, 4'd0, 8'd0, 8'd4, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd29, 4'd6, 8'd7, 8'd2, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd34, 4'd7, 8'd1, 8'd6, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        // Reads held off, fifth symbol hits a full buffer
        '{4'd8, 7'd39, 4'd8, 8'd2, 8'd2, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd44, 4'd9, 8'd3, 8'd1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd49, 4'd1, 8'd4, 8'd0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd54, 4'd2, 8'd5, 8'd7, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd59, 4'd3, 8'd6, 8'd3, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1},
        // Reads during writes across the ring wrap
        '{4'd8, 7'd64, 4'd4, 8'd7, 8'd5, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd69, 4'd5, 8'd8, 8'd6, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd74, 4'd6, 8'd9, 8'd8, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd79, 4'd7, 8'd1, 8'd9, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{4'd8, 7'd4,  4'd8, 8'd2, 8'd4, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0}
    };

    logic       clk;
    logic       cpri_reset = 1'b1;
    logic       enable     = 1'b0;
    cpri_word_t rx_data    = '0;
    logic       rvalid     = 1'b0;
    logic       rd_en      = 1'b0;
    logic       rready     = 1'b0;
    logic       rd_vld;
    logic       rx_sop;
    logic       tready;
    logic       tvalid;
    cpri_word_t tx_data;
    chip_addr_t tx_addr;
    logic       tx_last;
    logic       symb_eop;
    agc_t       fft_agc;
    logic       exp_vld    = 1'b0;
    cpri_word_t exp_word   = '0;
    logic       hdr_chk    = 1'b0;
    logic       exp_sop    = 1'b0;
    logic       exp_full   = 1'b0;
    int         chk_errs;
    int         chk_cnt;
    int         chk_pending;
    int         chk_symbs;
    int         exp_symbs  = 0;
    int         timeouts   = 0;

    tb_clk_gen u_clk (.o_clk(clk));

    cpri_rx_buffer u_dut (
        .i_clk(clk), .cpri_reset(cpri_reset), .i_enable(enable),
        .i_rx_data(rx_data), .i_rvalid(rvalid), .i_rd_en(rd_en),
        .i_rready(rready), .o_rd_vld(rd_vld), .o_rx_sop(rx_sop),
        .o_tready(tready), .o_tvalid(tvalid), .o_tx_data(tx_data),
        .o_tx_addr(tx_addr), .o_tx_last(tx_last), .o_symb_eop(symb_eop),
        .o_fft_agc(fft_agc)
    );

    cpri_rx_checker u_chk (
        .i_clk(clk), .cpri_reset(cpri_reset), .i_rd_vld(rd_vld),
        .i_rx_sop(rx_sop), .i_tready(tready), .i_tvalid(tvalid),
        .i_tx_data(tx_data), .i_tx_addr(tx_addr), .i_tx_last(tx_last),
        .i_symb_eop(symb_eop), .i_fft_agc(fft_agc), .i_exp_vld(exp_vld),
        .i_exp_word(exp_word), .i_hdr_chk(hdr_chk), .i_exp_sop(exp_sop),
        .i_exp_full(exp_full), .o_err_cnt(chk_errs), .o_chk_cnt(chk_cnt),
        .o_pending(chk_pending), .o_symb_cnt(chk_symbs)
    );

    // Output back-pressure, ready about seven cycles in eight
    always @(negedge clk) begin
        rready <= (($urandom % 8) != 0);
    end

    function automatic cpri_word_t header_word(input int n);
        cpri_word_t w;
        w = '0;
        w[HDR_PKG_LSB +: 4]  = STIM[n].pkg;
        w[HDR_PRB0_LSB +: 8] = STIM[n].prb0;
        w[HDR_PRB1_LSB +: 8] = STIM[n].prb1;
        w[HDR_SLOT_LSB +: 7] = STIM[n].slot;
        w[HDR_SYMB_LSB +: 4] = STIM[n].symb;
        w[7:0]               = 8'(n);
        return w;
    endfunction

    // Upper half carries entry and word number, so each AGC differs
    function automatic cpri_word_t payload_word(input int n, input int k);
        return {8'(n), 8'h5a, 16'(k), ~8'(n), 8'hc3, ~16'(k)};
    endfunction

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic send_symbol(input int n);
        int k;
        k          = 0;
        enable     = STIM[n].en;
        rd_en      = STIM[n].rd;
        rx_data    = header_word(n);
        rvalid     = 1'b1;
        exp_symbs += int'(STIM[n].keep);
        @(negedge clk);
        hdr_chk  = 1'b1;
        exp_sop  = STIM[n].sop;
        exp_full = STIM[n].full;
        while (k < SYMB_WORDS) begin
            if (($urandom % 4) == 0) begin
                rvalid  = 1'b0;
                exp_vld = 1'b0;
            end else begin
                rvalid   = 1'b1;
                rx_data  = payload_word(n, k);
                exp_vld  = STIM[n].keep;
                exp_word = rx_data;
                k++;
            end
            @(negedge clk);
            hdr_chk = 1'b0;
        end
        rvalid  = 1'b0;
        exp_vld = 1'b0;
    endtask

    task automatic send_range(input int first, input int last);
        for (int n = first; n <= last; n++) begin
            send_symbol(n);
        end
    endtask

    task automatic wait_drained(input string phase);
        int cycles;
        cycles = 0;
        while ((chk_symbs != exp_symbs || chk_pending != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (chk_symbs != exp_symbs || chk_pending != 0) begin
            timeouts++;
            $display("Timeout in %s: %0d of %0d symbols read out, %0d words still pending",
                     phase, chk_symbs, exp_symbs, chk_pending);
        end
    endtask

    initial begin
        void'($urandom(69));
        repeat (8) @(negedge clk);
        cpri_reset = 1'b0;
        send_range(0, 12);
        wait_drained("filter phase");
        send_range(13, 17);
        rd_en = 1'b1;
        wait_drained("full buffer phase");
        send_range(18, N_ENTRIES - 1);
        wait_drained("ring wrap phase");
        // Room for any stray word to show up
        repeat (8) @(negedge clk);
        $display("Checks: %0d, check errors: %0d, timeouts: %0d",
                 chk_cnt, chk_errs, timeouts);
        if (chk_errs == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpri_rx.f
hdl/cpri_rx_pkg.sv
hdl/cpri_hdr_filter.sv
hdl/cpri_symb_writer.sv
hdl/cpri_buf_level.sv
hdl/cpri_symb_ram.sv
hdl/cpri_symb_reader.sv
hdl/cpri_rx_buffer.sv
verif/tb_clk_gen.sv
verif/cpri_rx_checker.sv
verif/cpri_rx_tb.sv

// File: Makefile
# Verilator build and run for the CPRI uplink receive buffer

VERILATOR ?= verilator
TOP       ?= cpri_rx_tb
RTL_TOP   ?= cpri_rx_buffer
FLIST     ?= cpri_rx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
RTL_SRCS  ?= hdl/cpri_rx_pkg.sv hdl/cpri_hdr_filter.sv hdl/cpri_symb_writer.sv \
             hdl/cpri_buf_level.sv hdl/cpri_symb_ram.sv hdl/cpri_symb_reader.sv \
             hdl/cpri_rx_buffer.sv

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard hdl/*.sv) $(wildcard verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST RESULT: FAIL" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
